/* flist.f */
rtl/rc_pkg.sv
rtl/rc_adc_capture.sv
rtl/rc_apb_regs.sv
rtl/rc_switching_law.sv
rtl/rc_dead_time.sv
rtl/rc_top.sv
verif/rc_tb_chk.sv
verif/rc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the rc_top testbench with verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rc_tb \
   -f flist.f -Mdir obj_dir -o rc_tb_sim > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }

./obj_dir/rc_tb_sim > sim.log 2>&1

grep -q "ALL TESTS PASSED" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }

/* verif/rc_tb.sv */
`timescale 1ns/1ps

module rc_tb;
   import rc_pkg::*;

   localparam int N_LAW   = 300;    // samples per switching-law run
   localparam int N_RUNS  = 5;
   localparam int N_DT    = 6;      // dead-time steps
   localparam int MAX_DT  = 20;
   localparam int LAW_CYC = N_LAW + 3 * 3 + 3 + 10;
   localparam int DT_CYC  = 3 * 3 + (MAX_DT + 4) + 3 * 3 + 5 + (MAX_DT + 5);
   localparam int TIMEOUT_CYC = 150 + N_RUNS * LAW_CYC + N_DT * DT_CYC + 2 * 60 + 200;

   logic                      ADA_DCO;
   logic                      i_arst_n;
   logic                      i_psel, i_penable, i_pwrite;
   logic [3:0]                i_paddr;
   logic [31:0]               i_pwdata;
   logic [31:0]               o_prdata;
   logic                      o_pready, o_pslverr;
   logic signed [ADC_W-1:0]   i_ada_data, i_adb_data;
   logic                      i_ada_or, i_adb_or;
   logic [ADC_W-1:0]          o_da, o_db;
   logic                      o_q1, o_q2, o_sigma, o_jump;

   int                        cyc;          // cycles since time 0
   int                        n_checks;
   int                        n_errors;
   logic                      run_done;
   logic [31:0]               lfsr;
   logic [59:0]               dac_q[$];     // {tag, a, b}
   logic [59:0]               law_q[$];
   logic [1:0]                cur_mode;     // settings of the running law test
   logic signed [THETA_W-1:0] cur_theta;
   logic                      cur_en;
   logic                      ref_held;     // model of the held sigma
   int                        toggles;

   rc_top u_rc_top (.*);

   // ========================================
   // clock, cycle count, timeout
   // ========================================
   initial begin
      ADA_DCO = 1'b0;
      forever #4 ADA_DCO = ~ADA_DCO;
   end

   always @(posedge ADA_DCO) cyc <= cyc + 1;

   initial begin
      while (cyc < TIMEOUT_CYC) @(posedge ADA_DCO);
      $display("timeout: run still busy after %0d cycles", cyc);
      run_done = 1'b1;
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ========================================
   // random bits and reference model
   // ========================================
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32,22,2,1
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], lfsr_bit()};
      return v;
   endfunction

   // dac copy, negated sample on a mid-scale offset, 14-bit wrap
   function automatic logic [ADC_W-1:0] dac_ref(input logic signed [ADC_W-1:0] smp);
      int t;
      t = 8191 - int'(smp);
      return t[ADC_W-1:0];
   endfunction

   function automatic logic rc_ref_sigma(input logic [1:0] mode,
                                         input logic signed [THETA_W-1:0] theta,
                                         input logic signed [ADC_W-1:0] a,
                                         input logic signed [ADC_W-1:0] b,
                                         input logic held);
      logic signed [ADC_W-1:0] vc;
      logic signed [ADC_W-1:0] ic;
      int s;
      vc = -a;
      ic = -b;
      s  = int'(vc) + ((int'(theta) * int'(ic)) >>> 8);
      if (mode == 2'd1)
         s = -s;        // invert mode
      if (mode == 2'd2)
         return 1'b0;
      if (mode == 2'd3)
         return 1'b1;
      if (s > 0)
         return 1'b1;
      if (s < 0)
         return 1'b0;
      return held;      // on the surface
   endfunction

   // ========================================
   // compare tasks
   // ========================================
   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Error %s: expected 0x%08h, got 0x%08h", name, exp, act);
      end
   endtask

   task automatic check_sample(input string name, input logic [ADC_W-1:0] exp,
                               input logic [ADC_W-1:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Error %s: expected %0d, got %0d", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("Error %s: expected %b, got %b", name, exp, act);
      end
   endtask

   // ========================================
   // apb master
   // ========================================
   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
      @(posedge ADA_DCO);
      i_psel    <= 1'b1;   // setup phase
      i_penable <= 1'b0;
      i_pwrite  <= 1'b1;
      i_paddr   <= addr;
      i_pwdata  <= data;
      @(posedge ADA_DCO);
      i_penable <= 1'b1;   // access phase
      @(negedge ADA_DCO);
      while (o_pready !== 1'b1) @(negedge ADA_DCO);
      err = o_pslverr;
      @(posedge ADA_DCO);
      i_psel    <= 1'b0;
      i_penable <= 1'b0;
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
      @(posedge ADA_DCO);
      i_psel    <= 1'b1;
      i_penable <= 1'b0;
      i_pwrite  <= 1'b0;
      i_paddr   <= addr;
      @(posedge ADA_DCO);
      i_penable <= 1'b1;
      @(negedge ADA_DCO);
      while (o_pready !== 1'b1) @(negedge ADA_DCO);
      data = o_prdata;     // read mux is combinational
      err  = o_pslverr;
      @(posedge ADA_DCO);
      i_psel    <= 1'b0;
      i_penable <= 1'b0;
   endtask

   // ========================================
   // comparing process, dac at tag+2, sigma and jump at tag+4
   // ========================================
   always @(negedge ADA_DCO) begin : compare
      logic [59:0] e;
      logic        exp_sig;
      if (dac_q.size() != 0 && dac_q[0][59:28] + 2 == cyc) begin
         e = dac_q.pop_front();
         check_sample("dac_a", dac_ref(e[27:14]), o_da);
         check_sample("dac_b", dac_ref(e[13:0]), o_db);
      end
      if (law_q.size() != 0 && law_q[0][59:28] + 4 == cyc) begin
         e       = law_q.pop_front();
         exp_sig = rc_ref_sigma(cur_mode, cur_theta, e[27:14], e[13:0], ref_held);
         if (exp_sig != ref_held)
            toggles++;
         check_bit("sigma", exp_sig, o_sigma);
         check_bit("jump", exp_sig ^ ref_held, o_jump);   // pulse on each change
         ref_held = exp_sig;
         if (!cur_en) begin
            check_bit("q1_disabled", 1'b0, o_q1);   // bridge must stay off
            check_bit("q2_disabled", 1'b0, o_q2);
         end
      end
   end

   // ========================================
   // tests
   // ========================================
   task automatic test_registers();
      logic [31:0] rd;
      logic [31:0] wv;
      logic [31:0] wt;
      logic        err;
      apb_read(ADDR_CTRL, rd, err);
      check_word("ctrl_reset", 32'd0, rd);
      check_bit("ctrl_reset_err", 1'b0, err);
      apb_read(ADDR_THETA, rd, err);
      check_word("theta_reset", 32'd256, rd);   // 1.0 in Q8
      apb_read(ADDR_DEADTIME, rd, err);
      check_word("deadtime_reset", 32'd5, rd);
      apb_read(ADDR_STATUS, rd, err);
      check_word("status_reset", 32'd0, rd);
      apb_write(ADDR_CTRL, 32'h0000_0005, err);
      apb_read(ADDR_CTRL, rd, err);
      check_word("ctrl_rw", 32'h0000_0005, rd);
      wt = rand_bits(32);
      apb_write(ADDR_THETA, wt, err);
      apb_read(ADDR_THETA, rd, err);
      check_word("theta_rw", {16'd0, wt[15:0]}, rd);
      wv = rand_bits(32);
      apb_write(ADDR_DEADTIME, wv, err);
      apb_read(ADDR_DEADTIME, rd, err);
      check_word("deadtime_rw", {22'd0, wv[9:0]}, rd);
      apb_write(4'h6, 32'hffff_ffff, err);      // unmapped
      check_bit("unmapped_write_err", 1'b1, err);
      apb_read(4'h6, rd, err);
      check_bit("unmapped_read_err", 1'b1, err);
      check_word("unmapped_read", 32'd0, rd);
      apb_read(ADDR_CTRL, rd, err);
      check_word("ctrl_after_unmapped", 32'h0000_0005, rd);
      apb_read(ADDR_THETA, rd, err);             // 0x6 shares bits 3:2 with theta
      check_word("theta_after_unmapped", {16'd0, wt[15:0]}, rd);
      apb_write(ADDR_CTRL, 32'd0, err);
   endtask

   task automatic law_run(input logic [1:0] mode, input logic signed [THETA_W-1:0] theta,
                          input logic en);
      logic                    err;
      logic signed [ADC_W-1:0] a, b;
      @(posedge ADA_DCO);
      i_ada_data <= '0;     // zero surface while the settings change
      i_adb_data <= '0;
      apb_write(ADDR_CTRL, {29'd0, MODE_FORCE_LO, en}, err);
      apb_write(ADDR_THETA, {16'd0, theta}, err);
      apb_write(ADDR_CTRL, {29'd0, mode, en}, err);
      repeat (3) @(posedge ADA_DCO);
      cur_mode  = mode;
      cur_theta = theta;
      cur_en    = en;
      // forced low, then zero samples under the new mode
      ref_held  = rc_ref_sigma(mode, theta, '0, '0, 1'b0);
      toggles   = 0;
      repeat (N_LAW) begin
         @(posedge ADA_DCO);
         a = rand_bits(ADC_W);
         b = rand_bits(ADC_W);
         i_ada_data <= a;
         i_adb_data <= b;
         dac_q.push_back({cyc, a, b});
         law_q.push_back({cyc, a, b});
      end
      while (law_q.size() != 0) @(negedge ADA_DCO);
   endtask

   task automatic test_dead_time(input int dt);
      logic err;
      int   n;
      apb_write(ADDR_DEADTIME, dt, err);
      apb_write(ADDR_CTRL, {29'd0, MODE_FORCE_LO, 1'b1}, err);
      repeat (dt + 4) @(negedge ADA_DCO);
      check_bit("dt_q1_settled", 1'b1, o_q1);
      check_bit("dt_q2_settled", 1'b0, o_q2);
      apb_write(ADDR_CTRL, {29'd0, MODE_FORCE_HI, 1'b1}, err);
      n = 0;
      @(negedge ADA_DCO);
      while (o_sigma !== 1'b1 && n < 4) begin
         @(negedge ADA_DCO);
         n++;
      end
      if (o_sigma !== 1'b1) begin
         n_errors++;
         $display("sigma did not rise after the switch to force high");
      end
      check_bit("dt_q1_at_step", 1'b1, o_q1);
      n = 0;
      do begin
         @(negedge ADA_DCO);
         n++;
         if (n == 1)
            check_bit("dt_q1_fall", 1'b0, o_q1);  // one cycle after the step
      end while (o_q2 !== 1'b1 && n < MAX_DT + 5);
      check_word("dt_q2_delay", dt, n);
   endtask

   task automatic test_status(input string tag, input logic chan_b);
      logic [31:0] rd;
      logic [31:0] flag;
      logic        err;
      flag = chan_b ? 32'd2 : 32'd1;
      @(posedge ADA_DCO);
      if (chan_b)
         i_adb_or <= 1'b1;
      else
         i_ada_or <= 1'b1;
      @(posedge ADA_DCO);
      i_ada_or <= 1'b0;     // single-cycle flag
      i_adb_or <= 1'b0;
      repeat (3) @(posedge ADA_DCO);
      apb_read(ADDR_STATUS, rd, err);
      check_word({tag, "_set"}, flag, rd);
      repeat (8) @(posedge ADA_DCO);
      apb_read(ADDR_STATUS, rd, err);
      check_word({tag, "_sticky"}, flag, rd);
      apb_write(ADDR_STATUS, 32'd0, err);
      apb_read(ADDR_STATUS, rd, err);
      check_word({tag, "_clear"}, 32'd0, rd);
   endtask

   // ========================================
   // main sequence
   // ========================================
   initial begin : main
      lfsr       = 32'h4ee4;
      run_done   = 1'b0;
      i_arst_n   <= 1'b0;
      i_psel     <= 1'b0;
      i_penable  <= 1'b0;
      i_pwrite   <= 1'b0;
      i_paddr    <= '0;
      i_pwdata   <= '0;
      i_ada_data <= '0;
      i_adb_data <= '0;
      i_ada_or   <= 1'b0;
      i_adb_or   <= 1'b0;
      repeat (2) @(posedge ADA_DCO);
      i_arst_n <= 1'b1;
      @(posedge ADA_DCO);
      test_registers();
      law_run(MODE_HYBRID, rand_bits(THETA_W), 1'b0);   // bridge disabled
      if (toggles == 0) begin
         n_errors++;
         $display("sigma never switched while the bridge was disabled");
      end
      law_run(MODE_INVERT, rand_bits(THETA_W), 1'b1);
      law_run(MODE_FORCE_LO, rand_bits(THETA_W), 1'b1);
      law_run(MODE_FORCE_HI, rand_bits(THETA_W), 1'b1);
      law_run(MODE_HYBRID, rand_bits(THETA_W), 1'b1);
      repeat (N_DT)
         test_dead_time(1 + int'(rand_bits(5) % MAX_DT));
      test_status("status_a", 1'b0);
      test_status("status_b", 1'b1);
      $display("checks %0d, errors %0d", n_checks, n_errors);
      run_done = 1'b1;
      if (n_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // run stopped by something other than the main sequence or the timeout
   final begin
      if (!run_done)
         $display("SOME TESTS FAILED");
   end

endmodule

/* verif/rc_tb_chk.sv */
`timescale 1ns/1ps

module rc_tb_chk (
   input logic ADA_DCO,
   input logic i_arst_n,
   input logic i_psel,
   input logic i_penable,
   input logic i_pready,
   input logic i_pslverr,
   input logic i_q1,
   input logic i_q2
);

   // ========================================
   // bridge gates
   // ========================================
   // both legs on means shoot-through
   a_gate_excl: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      !(i_q1 && i_q2))
      else $error("q1 and q2 are high in the same cycle");

   // ========================================
   // apb response
   // ========================================
   a_pready_high: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      i_pready)
      else $error("pready dropped, the slave has no wait states");

   a_pslverr_access: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      i_pslverr |-> (i_psel && i_penable))   // error only in the access phase
      else $error("pslverr high outside an access phase");

endmodule

bind rc_top rc_tb_chk u_chk (
   .ADA_DCO   (ADA_DCO),
   .i_arst_n  (i_arst_n),
   .i_psel    (i_psel),
   .i_penable (i_penable),
   .i_pready  (o_pready),
   .i_pslverr (o_pslverr),
   .i_q1      (o_q1),
   .i_q2      (o_q2)
);

/* rtl/rc_top.sv */
`timescale 1ns/1ps

module rc_top (
   input  logic                            i_arst_n,
   input  logic                            ADA_DCO,
   // apb
   input  logic                            i_psel,
   input  logic                            i_penable,
   input  logic                            i_pwrite,
   input  logic [3:0]                      i_paddr,
   input  logic [31:0]                     i_pwdata,
   output logic [31:0]                     o_prdata,
   output logic                            o_pready,
   output logic                            o_pslverr,
   // adc
   input  logic signed [rc_pkg::ADC_W-1:0] i_ada_data,
   input  logic signed [rc_pkg::ADC_W-1:0] i_adb_data,
   input  logic                            i_ada_or,
   input  logic                            i_adb_or,
   // dac and bridge
   output logic [rc_pkg::ADC_W-1:0]        o_da,
   output logic [rc_pkg::ADC_W-1:0]        o_db,
   output logic                            o_q1,
   output logic                            o_q2,
   output logic                            o_sigma,
   output logic                            o_jump
);
   import rc_pkg::*;

   logic signed [ADC_W-1:0]   w_vc;
   logic signed [ADC_W-1:0]   w_ic;
   logic                      w_ora, w_orb;
   logic                      r_enable;     // from ctrl register
   logic [1:0]                r_mode;
   logic signed [THETA_W-1:0] r_theta;
   logic [DT_W-1:0]           r_deadtime;
   logic                      w_sigma;
   logic                      w_q1, w_q2;   // before enable gating

   rc_adc_capture u_capture (
      .i_arst_n   (i_arst_n),
      .ADA_DCO    (ADA_DCO),
      .i_ada_data (i_ada_data),
      .i_adb_data (i_adb_data),  // channel b sampled on the a clock
      .i_ada_or   (i_ada_or),
      .i_adb_or   (i_adb_or),
      .o_vc       (w_vc),
      .o_ic       (w_ic),
      .o_da       (o_da),
      .o_db       (o_db),
      .o_ora      (w_ora),
      .o_orb      (w_orb)
   );

   rc_apb_regs u_regs (
      .i_arst_n   (i_arst_n),
      .ADA_DCO    (ADA_DCO),
      .i_psel     (i_psel),
      .i_penable  (i_penable),
      .i_pwrite   (i_pwrite),
      .i_paddr    (i_paddr),
      .i_pwdata   (i_pwdata),
      .o_prdata   (o_prdata),
      .o_pready   (o_pready),
      .o_pslverr  (o_pslverr),
      .i_ora      (w_ora),
      .i_orb      (w_orb),
      .o_enable   (r_enable),
      .o_mode     (r_mode),
      .o_theta    (r_theta),
      .o_deadtime (r_deadtime)
   );

   rc_switching_law u_law (
      .i_arst_n (i_arst_n),
      .ADA_DCO  (ADA_DCO),
      .i_vc     (w_vc),
      .i_ic     (w_ic),
      .i_theta  (r_theta),
      .i_mode   (r_mode),
      .o_sigma  (w_sigma),
      .o_jump   (o_jump)
   );

   // ========================================
   // bridge gates
   // ========================================
   rc_dead_time u_dt_q1 (
      .i_arst_n   (i_arst_n),
      .ADA_DCO    (ADA_DCO),
      .i_signal   (~w_sigma),   // low side leg
      .i_deadtime (r_deadtime),
      .o_signal   (w_q1)
   );

   rc_dead_time u_dt_q2 (
      .i_arst_n   (i_arst_n),
      .ADA_DCO    (ADA_DCO),
      .i_signal   (w_sigma),
      .i_deadtime (r_deadtime),
      .o_signal   (w_q2)
   );

   assign o_q1    = w_q1 & r_enable;  // bridge off when disabled
   assign o_q2    = w_q2 & r_enable;
   assign o_sigma = w_sigma;          // law keeps running for monitoring

endmodule

/* rtl/rc_dead_time.sv */
`timescale 1ns/1ps

module rc_dead_time (
   input  logic                        i_arst_n,
   input  logic                        ADA_DCO,
   input  logic                        i_signal,     // raw gate request
   input  logic [rc_pkg::DT_W-1:0]     i_deadtime,   // cycles of delay on the rising edge
   output logic                        o_signal      // delayed gate
);
   import rc_pkg::*;

   logic [DT_W-1:0] r_cnt;       // cycles the input has been high
   logic [DT_W-1:0] w_cnt_nxt;

   // ========================================
   // saturating high-time counter
   // ========================================
   always_comb begin
      if (!i_signal)
         w_cnt_nxt = '0;              // restart on every low
      else if (r_cnt >= i_deadtime)
         w_cnt_nxt = i_deadtime;      // saturate, also clamps a lowered setting
      else
         w_cnt_nxt = r_cnt + 1'b1;
   end

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         r_cnt    <= '0;
         o_signal <= 1'b0;
      end else begin
         r_cnt    <= w_cnt_nxt;
         // rises once the count is reached, drops one cycle after the input
         o_signal <= i_signal && (w_cnt_nxt >= i_deadtime);
      end
   end

endmodule

/* rtl/rc_switching_law.sv */
`timescale 1ns/1ps

module rc_switching_law (
   input  logic                              i_arst_n,
   input  logic                              ADA_DCO,
   input  logic signed [rc_pkg::ADC_W-1:0]   i_vc,      // capacitor voltage
   input  logic signed [rc_pkg::ADC_W-1:0]   i_ic,      // inductor current
   input  logic signed [rc_pkg::THETA_W-1:0] i_theta,   // surface gain, Q8
   input  logic [1:0]                        i_mode,
   output logic                              o_sigma,   // switching state
   output logic                              o_jump     // pulse on sigma change
);
   import rc_pkg::*;

   logic signed [SURF_W-1:0] w_prod;      // theta * iC, full precision
   logic signed [SURF_W-1:0] r_prod_sc;   // stage 1, scaled back to integer
   logic signed [ADC_W-1:0]  r_vc_d;      // vC lined up with the product
   logic signed [SURF_W-1:0] w_surf;      // s
   logic signed [SURF_W-1:0] w_rule;      // s or -s, by mode
   logic                     w_sigma_nxt;

   // both operands signed, so they are sign extended to 32 bits first
   assign w_prod = i_theta * i_ic;

   // ========================================
   // stage 1, product
   // ========================================
   always_ff @(posedge ADA_DCO) begin
      r_prod_sc <= w_prod >>> THETA_FRAC;  // arithmetic, keeps sign
      r_vc_d    <= i_vc;
   end

   // ========================================
   // stage 2, surface and mode rule
   // ========================================
   assign w_surf = r_vc_d + r_prod_sc;
   assign w_rule = (i_mode == MODE_INVERT) ? -w_surf : w_surf;  // |s| far below 2^31

   always_comb begin
      case (i_mode)
         MODE_HYBRID, MODE_INVERT: begin
            if (w_rule > 0)
               w_sigma_nxt = 1'b1;
            else if (w_rule < 0)
               w_sigma_nxt = 1'b0;
            else
               w_sigma_nxt = o_sigma;   // on the surface, hold
         end
         MODE_FORCE_LO: w_sigma_nxt = 1'b0;
         default:       w_sigma_nxt = 1'b1;   // force high
      endcase
   end

   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_sigma <= 1'b0;
         o_jump  <= 1'b0;
      end else begin
         o_sigma <= w_sigma_nxt;
         o_jump  <= w_sigma_nxt ^ o_sigma;  // high in the cycle sigma shows its new value
      end
   end

endmodule

/* rtl/rc_apb_regs.sv */
`timescale 1ns/1ps

module rc_apb_regs (
   input  logic                              i_arst_n,
   input  logic                              ADA_DCO,
   input  logic                              i_psel,
   input  logic                              i_penable,
   input  logic                              i_pwrite,
   input  logic [3:0]                        i_paddr,
   input  logic [31:0]                       i_pwdata,
   output logic [31:0]                       o_prdata,
   output logic                              o_pready,
   output logic                              o_pslverr,
   input  logic                              i_ora,       // channel a out of range
   input  logic                              i_orb,       // channel b out of range
   output logic                              o_enable,
   output logic [1:0]                        o_mode,
   output logic signed [rc_pkg::THETA_W-1:0] o_theta,
   output logic [rc_pkg::DT_W-1:0]           o_deadtime
);
   import rc_pkg::*;

   logic       w_access;   // apb access phase
   logic       w_valid;    // address hits one of the four registers
   logic       w_wr;
   logic [1:0] r_status;   // sticky {b, a}

   assign w_access  = i_psel & i_penable;
   assign w_wr      = w_access & i_pwrite & w_valid;
   assign o_pready  = 1'b1;                  // no wait states
   assign o_pslverr = w_access & ~w_valid;

   always_comb begin
      case (i_paddr)
         ADDR_CTRL, ADDR_THETA, ADDR_DEADTIME, ADDR_STATUS: w_valid = 1'b1;
         default:                                            w_valid = 1'b0;
      endcase
   end

   // ========================================
   // control registers
   // ========================================
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_enable   <= CTRL_RST[0];
         o_mode     <= CTRL_RST[2:1];
         o_theta    <= THETA_RST;
         o_deadtime <= DT_RST;
      end else if (w_wr) begin
         case (i_paddr)
            ADDR_CTRL: begin
               o_enable <= i_pwdata[0];
               o_mode   <= i_pwdata[2:1];
            end
            ADDR_THETA:    o_theta    <= i_pwdata[THETA_W-1:0];
            ADDR_DEADTIME: o_deadtime <= i_pwdata[DT_W-1:0];
            default:       ;   // status handled below
         endcase
      end
   end

   // sticky flags, any status write clears, a new flag beats the clear
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         r_status <= 2'b00;
      end else if (w_wr && (i_paddr == ADDR_STATUS)) begin
         r_status <= {i_orb, i_ora};
      end else begin
         r_status <= r_status | {i_orb, i_ora};
      end
   end

   // ========================================
   // read mux
   // ========================================
   always_comb begin
      case (i_paddr)
         ADDR_CTRL:     o_prdata = {29'd0, o_mode, o_enable};
         ADDR_THETA:    o_prdata = {{(32-THETA_W){1'b0}}, o_theta};  // zero filled
         ADDR_DEADTIME: o_prdata = {{(32-DT_W){1'b0}}, o_deadtime};
         ADDR_STATUS:   o_prdata = {30'd0, r_status};
         default:       o_prdata = 32'd0;   // unmapped reads as zero
      endcase
   end

endmodule

/* rtl/rc_adc_capture.sv */
`timescale 1ns/1ps

module rc_adc_capture (
   input  logic                            i_arst_n,
   input  logic                            ADA_DCO,
   input  logic signed [rc_pkg::ADC_W-1:0] i_ada_data,  // capacitor voltage
   input  logic signed [rc_pkg::ADC_W-1:0] i_adb_data,  // inductor current
   input  logic                            i_ada_or,
   input  logic                            i_adb_or,
   output logic signed [rc_pkg::ADC_W-1:0] o_vc,
   output logic signed [rc_pkg::ADC_W-1:0] o_ic,
   output logic        [rc_pkg::ADC_W-1:0] o_da,
   output logic        [rc_pkg::ADC_W-1:0] o_db,
   output logic                            o_ora,
   output logic                            o_orb
);
   import rc_pkg::*;

   logic signed [ADC_W-1:0] w_neg_a;  // sensor polarity is inverted on the board
   logic signed [ADC_W-1:0] w_neg_b;

   assign w_neg_a = -i_ada_data;  // -8192 wraps onto itself
   assign w_neg_b = -i_adb_data;

   // ========================================
   // sample and dac copy registers
   // ========================================
   always_ff @(posedge ADA_DCO) begin
      o_vc <= w_neg_a;
      o_ic <= w_neg_b;
      // offset binary for the dac, wraps at 14 bits
      o_da <= $unsigned(w_neg_a) + DAC_OFFSET;
      o_db <= $unsigned(w_neg_b) + DAC_OFFSET;
   end

   // out-of-range bits, one cycle to line up with the samples
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ora <= 1'b0;
         o_orb <= 1'b0;
      end else begin
         o_ora <= i_ada_or;
         o_orb <= i_adb_or;
      end
   end

endmodule

/* rtl/rc_pkg.sv */
package rc_pkg;

   // ========================================
   // datapath widths
   // ========================================
   localparam int ADC_W   = 14;    // adc sample, two's complement
   localparam int THETA_W = 16;    // signed surface gain, Q8
   localparam int DT_W    = 10;    // dead-time count
   localparam int SURF_W  = 32;    // switching surface

   localparam int THETA_FRAC = 8;  // fractional bits of theta

   // mid-scale offset for the dac copies
   localparam logic [ADC_W-1:0] DAC_OFFSET = 14'd8191;

   // ========================================
   // switching modes
   // ========================================
   localparam logic [1:0] MODE_HYBRID   = 2'd0;  // sigma follows sign of s
   localparam logic [1:0] MODE_INVERT   = 2'd1;  // sigma follows sign of -s
   localparam logic [1:0] MODE_FORCE_LO = 2'd2;
   localparam logic [1:0] MODE_FORCE_HI = 2'd3;

   // ========================================
   // apb register map
   // ========================================
   localparam logic [3:0] ADDR_CTRL     = 4'h0;  // {mode, enable}
   localparam logic [3:0] ADDR_THETA    = 4'h4;
   localparam logic [3:0] ADDR_DEADTIME = 4'h8;
   localparam logic [3:0] ADDR_STATUS   = 4'hC;  // sticky out-of-range

   // reset values
   localparam logic [2:0]                CTRL_RST  = 3'b000;   // disabled, hybrid
   localparam logic signed [THETA_W-1:0] THETA_RST = 16'sd256; // gain 1.0
   localparam logic [DT_W-1:0]           DT_RST    = 10'd5;

endpackage
